// File: src/lock_pkg.sv
`default_nettype none

package lock_pkg;

    // command keys on the one-hot keypad
    localparam int KEY_ENTER       = 0;
    localparam int KEY_CLEAR_ALL   = 8;
    localparam int KEY_CLEAR_ENTRY = 12;

    // bit position of each digit key, indexed by digit value
    localparam int DIGIT_KEY_BIT [10] = '{3, 7, 6, 5, 11, 10, 9, 15, 14, 13};

    // bits 1, 2 and 4 are not wired to a key
    localparam logic [15:0] KEY_UNUSED_MASK = 16'h0016;

    localparam int ENTRY_LEN = 3;             // digits per code
    localparam int DISPLAY_W = 4 * ENTRY_LEN;

    typedef logic [3:0] digit_t;

    localparam digit_t DIGIT_BLANK = 4'hF;

    // one display word, seen as digit nibbles or as a whole glyph
    typedef union packed {
        digit_t [ENTRY_LEN-1:0] digits;       // [2] leftmost, [0] newest
        logic   [DISPLAY_W-1:0] glyph;
    } display_u;

    localparam logic [DISPLAY_W-1:0] GLYPH_BLANK   = 12'hFFF;
    localparam logic [DISPLAY_W-1:0] GLYPH_OPEN    = 12'hBCC;
    localparam logic [DISPLAY_W-1:0] GLYPH_LOCKOUT = 12'h000;

    typedef enum logic {
        DISP_ENTRY,   // show entered digits
        DISP_STATUS   // show a status glyph
    } display_mode_t;

    typedef enum logic [1:0] {
        GLYPH_SEL_OPEN,
        GLYPH_SEL_LOCKOUT
    } glyph_sel_t;

endpackage

`default_nettype wire

// File: src/keypad_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module keypad_decoder
    import lock_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic [15:0] keys,
    output logic        digit_valid,
    output digit_t      digit,
    output logic        enter,
    output logic        clear_entry,
    output logic        clear_all
);

    logic [15:0] keys_q;      // previous sample
    logic        single_key;
    logic        new_press;
    logic        dig_hit;
    digit_t      dig_val;

    // exactly one key down and none of the dead bits
    assign single_key = $onehot(keys) && ((keys & KEY_UNUSED_MASK) == '0);
    assign new_press  = single_key && (keys != keys_q);  // held key stays quiet

    // map the single key to its digit value
    always_comb begin
        dig_hit = 1'b0;
        dig_val = DIGIT_BLANK;
        for (int i = 0; i < 10; i++) begin
            if (keys[DIGIT_KEY_BIT[i]]) begin
                dig_hit = 1'b1;
                dig_val = digit_t'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            keys_q      <= '0;
            digit_valid <= 1'b0;
            enter       <= 1'b0;
            clear_entry <= 1'b0;
            clear_all   <= 1'b0;
        end else begin
            keys_q      <= keys;
            digit_valid <= new_press && dig_hit;
            enter       <= new_press && keys[KEY_ENTER];
            clear_entry <= new_press && keys[KEY_CLEAR_ENTRY];
            clear_all   <= new_press && keys[KEY_CLEAR_ALL];
        end
    end

    // value of the latest digit event
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            digit <= DIGIT_BLANK;
        end else if (new_press && dig_hit) begin
            digit <= dig_val;
        end
    end

endmodule

`default_nettype wire

// File: src/code_register.sv
`timescale 1ns/10ps
`default_nettype none

module code_register
    import lock_pkg::*;
#(
    parameter logic [DISPLAY_W-1:0] PASSCODE = 12'h246
) (
    input  logic          clk,
    input  logic          arst_n,
    input  digit_t        digit,
    input  logic          accept_digit,
    input  logic          entry_clear,
    input  display_mode_t display_mode,
    input  glyph_sel_t    glyph_sel,
    output logic          entry_full,
    output logic          code_match,
    output logic [1:0]    digit_count,
    output display_u      display
);

    display_u   entry_q;   // entered digits, newest on the right
    logic [1:0] count_q;

    // shift left on each accepted digit until the entry is full
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            entry_q.glyph <= GLYPH_BLANK;
            count_q       <= '0;
        end else if (entry_clear) begin
            entry_q.glyph <= GLYPH_BLANK;   // all nibbles blank
            count_q       <= '0;
        end else if (accept_digit && !entry_full) begin
            entry_q.digits <= {entry_q.digits[ENTRY_LEN-2:0], digit};
            count_q        <= count_q + 2'd1;
        end
    end

    assign entry_full  = (count_q == 2'(ENTRY_LEN));
    assign code_match  = (entry_q.glyph == PASSCODE);  // whole word compare
    assign digit_count = count_q;

    // status mode overrides the digits with a glyph
    always_comb begin
        display = entry_q;
        if (display_mode == DISP_STATUS) begin
            if (glyph_sel == GLYPH_SEL_LOCKOUT) begin
                display.glyph = GLYPH_LOCKOUT;
            end else begin
                display.glyph = GLYPH_OPEN;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/lock_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module lock_fsm
    import lock_pkg::*;
#(
    parameter int MAX_TRIES = 6,
    parameter int TRIES_W   = 4
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               digit_valid,
    input  logic               enter,
    input  logic               clear_entry,
    input  logic               clear_all,
    input  logic               entry_full,
    input  logic               code_match,
    input  logic               alarm_ack,
    output logic               accept_digit,
    output logic               entry_clear,
    output display_mode_t      display_mode,
    output glyph_sel_t         glyph_sel,
    output logic               alarm_req,
    output logic [TRIES_W-1:0] tries
);

    typedef enum logic [1:0] {
        ST_ENTRY,
        ST_OPEN,
        ST_LOCKOUT
    } lock_state_t;

    // four-phase handshake with the alarm timer
    typedef enum logic [1:0] {
        ALM_IDLE,
        ALM_REQ,      // req high, waiting for ack
        ALM_RELEASE   // req dropped, waiting for ack to fall
    } alarm_phase_t;

    lock_state_t        state_q;
    lock_state_t        state_d;
    alarm_phase_t       alm_q;
    alarm_phase_t       alm_d;
    logic [TRIES_W-1:0] tries_q;
    logic [TRIES_W-1:0] tries_d;
    logic               start_alarm;

    // decoder never gives two events in one cycle
    always_comb begin
        state_d     = state_q;
        tries_d     = tries_q;
        entry_clear = 1'b0;
        start_alarm = 1'b0;
        if (clear_all) begin
            state_d     = ST_ENTRY;
            tries_d     = '0;
            entry_clear = 1'b1;
        end else if (clear_entry && state_q != ST_LOCKOUT) begin
            state_d     = ST_ENTRY;
            entry_clear = 1'b1;
        end else if (enter && state_q == ST_ENTRY && entry_full) begin
            if (code_match) begin
                state_d = ST_OPEN;
            end else begin
                entry_clear = 1'b1;   // wrong code blanks the entry
                tries_d     = tries_q + 1'b1;
                start_alarm = 1'b1;
                if (tries_d == TRIES_W'(MAX_TRIES)) begin
                    state_d = ST_LOCKOUT;
                end
            end
        end
    end

    // a failure mid-handshake does not restart the buzzer
    always_comb begin
        alm_d = alm_q;
        case (alm_q)
            ALM_IDLE: begin
                if (start_alarm) begin
                    alm_d = ALM_REQ;
                end
            end
            ALM_REQ: begin
                if (alarm_ack) begin
                    alm_d = ALM_RELEASE;
                end
            end
            ALM_RELEASE: begin
                if (!alarm_ack) begin
                    alm_d = ALM_IDLE;
                end
            end
            default: alm_d = ALM_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= ST_ENTRY;
            alm_q   <= ALM_IDLE;
            tries_q <= '0;
        end else begin
            state_q <= state_d;
            alm_q   <= alm_d;
            tries_q <= tries_d;
        end
    end

    assign accept_digit = digit_valid && (state_q == ST_ENTRY);  // open/lockout drop digits
    assign display_mode = (state_q == ST_ENTRY) ? DISP_ENTRY : DISP_STATUS;
    assign glyph_sel    = (state_q == ST_LOCKOUT) ? GLYPH_SEL_LOCKOUT : GLYPH_SEL_OPEN;
    assign alarm_req    = (alm_q == ALM_REQ);
    assign tries        = tries_q;

endmodule

`default_nettype wire

// File: src/alarm_timer.sv
`timescale 1ns/10ps
`default_nettype none

module alarm_timer #(
    parameter int unsigned BUZZ_CYCLES = 150_000_000
) (
    input  logic clk,
    input  logic arst_n,
    input  logic alarm_req,
    output logic alarm_ack,
    output logic buzzer
);

    // counts 0 .. BUZZ_CYCLES-1
    localparam int CNT_W = (BUZZ_CYCLES > 1) ? $clog2(BUZZ_CYCLES) : 1;

    logic [CNT_W-1:0] cnt_q;
    logic             idle;
    logic             cnt_done;

    assign idle     = !buzzer && !alarm_ack;
    assign cnt_done = (cnt_q == CNT_W'(BUZZ_CYCLES - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt_q     <= '0;
            buzzer    <= 1'b0;
            alarm_ack <= 1'b0;
        end else if (idle) begin
            if (alarm_req) begin
                buzzer <= 1'b1;   // one cycle after req
                cnt_q  <= '0;
            end
        end else if (buzzer) begin
            if (cnt_done) begin
                buzzer    <= 1'b0;
                alarm_ack <= 1'b1;   // ack with the falling buzzer
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end else if (!alarm_req) begin
            alarm_ack <= 1'b0;   // req dropped, close the handshake
        end
    end

endmodule

`default_nettype wire

// File: src/keypad_lock.sv
`timescale 1ns/10ps
`default_nettype none

module keypad_lock
    import lock_pkg::*;
#(
    parameter logic [DISPLAY_W-1:0] PASSCODE    = 12'h246,
    parameter int                   MAX_TRIES   = 6,
    parameter int                   TRIES_W     = 4,
    parameter int unsigned          BUZZ_CYCLES = 150_000_000
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic [15:0]        keys,
    output display_u           display,
    output logic [1:0]         digit_count,
    output logic [TRIES_W-1:0] tries,
    output logic               buzzer
);

    // key events
    logic          digit_valid;
    digit_t        digit;
    logic          enter;
    logic          clear_entry;
    logic          clear_all;

    // entry control and status
    logic          accept_digit;
    logic          entry_clear;
    display_mode_t display_mode;
    glyph_sel_t    glyph_sel;
    logic          entry_full;
    logic          code_match;

    // alarm handshake
    logic          alarm_req;
    logic          alarm_ack;

    keypad_decoder u_decoder (
        .clk         (clk),
        .arst_n      (arst_n),
        .keys        (keys),
        .digit_valid (digit_valid),
        .digit       (digit),
        .enter       (enter),
        .clear_entry (clear_entry),
        .clear_all   (clear_all)
    );

    code_register #(
        .PASSCODE (PASSCODE)
    ) u_code (
        .clk          (clk),
        .arst_n       (arst_n),
        .digit        (digit),
        .accept_digit (accept_digit),
        .entry_clear  (entry_clear),
        .display_mode (display_mode),
        .glyph_sel    (glyph_sel),
        .entry_full   (entry_full),
        .code_match   (code_match),
        .digit_count  (digit_count),
        .display      (display)
    );

    lock_fsm #(
        .MAX_TRIES (MAX_TRIES),
        .TRIES_W   (TRIES_W)
    ) u_fsm (
        .clk          (clk),
        .arst_n       (arst_n),
        .digit_valid  (digit_valid),
        .enter        (enter),
        .clear_entry  (clear_entry),
        .clear_all    (clear_all),
        .entry_full   (entry_full),
        .code_match   (code_match),
        .alarm_ack    (alarm_ack),
        .accept_digit (accept_digit),
        .entry_clear  (entry_clear),
        .display_mode (display_mode),
        .glyph_sel    (glyph_sel),
        .alarm_req    (alarm_req),
        .tries        (tries)
    );

    alarm_timer #(
        .BUZZ_CYCLES (BUZZ_CYCLES)
    ) u_alarm (
        .clk       (clk),
        .arst_n    (arst_n),
        .alarm_req (alarm_req),
        .alarm_ack (alarm_ack),
        .buzzer    (buzzer)
    );

endmodule

`default_nettype wire

// File: bench/lock_model.svh
`ifndef LOCK_MODEL_SVH
`define LOCK_MODEL_SVH

typedef struct packed {
    logic [11:0]        entry;   // digit nibbles, newest on the right
    logic [1:0]         count;
    logic [TRIES_W-1:0] tries;
    logic [1:0]         st;
} model_t;

localparam logic [1:0] M_ENTRY = 2'd0;
localparam logic [1:0] M_OPEN  = 2'd1;
localparam logic [1:0] M_LOCK  = 2'd2;

model_t model;

// keypad layout, -1 for anything but a single digit key
function automatic int key_digit(input logic [15:0] k);
    case (k)
        16'h0008: return 0;
        16'h0080: return 1;
        16'h0040: return 2;
        16'h0020: return 3;
        16'h0800: return 4;
        16'h0400: return 5;
        16'h0200: return 6;
        16'h8000: return 7;
        16'h4000: return 8;
        16'h2000: return 9;
        default:  return -1;
    endcase
endfunction

// next model state after one press
function automatic model_t model_step(input model_t m, input logic [15:0] k);
    model_t n;
    int     d;
    n = m;
    d = key_digit(k);
    if (d >= 0 && m.st == M_ENTRY && m.count < 2'd3) begin
        n.entry = {m.entry[7:0], 4'(d)};
        n.count = m.count + 2'd1;
    end else if (k == 16'h0001 && m.st == M_ENTRY && m.count == 2'd3) begin
        if (m.entry == PASSCODE) begin
            n.st = M_OPEN;
        end else begin
            n.entry = 12'hFFF;   // wrong code blanks the entry
            n.count = 2'd0;
            n.tries = m.tries + 1'b1;
            if (n.tries == MAX_TRIES) begin
                n.st = M_LOCK;
            end
        end
    end else if (k == 16'h0100 || (k == 16'h1000 && m.st != M_LOCK)) begin
        n.entry = 12'hFFF;
        n.count = 2'd0;
        n.st    = M_ENTRY;
        if (k == 16'h0100) begin
            n.tries = '0;   // clear all also forgets the tries
        end
    end
    return n;
endfunction

function automatic display_u model_display(input model_t m);
    display_u v;
    case (m.st)
        M_OPEN:  v.glyph = GLYPH_OPEN;
        M_LOCK:  v.glyph = GLYPH_LOCKOUT;
        default: v.glyph = m.entry;
    endcase
    return v;
endfunction

task automatic check_display(input display_u act, input display_u exp);
    if (act !== exp) begin
        err_display++;
        $display("[FAIL] display: got %h, expected %h", act.glyph, exp.glyph);
    end
endtask

task automatic check_count(input logic [1:0] act, input logic [1:0] exp);
    if (act !== exp) begin
        err_count++;
        $display("[FAIL] digit_count: got %h, expected %h", act, exp);
    end
endtask

task automatic check_tries(input logic [TRIES_W-1:0] act, input logic [TRIES_W-1:0] exp);
    if (act !== exp) begin
        err_tries++;
        $display("[FAIL] tries: got %h, expected %h", act, exp);
    end
endtask

task automatic check_buzz_len(input int act, input int exp);
    if (act != exp) begin
        err_buzz++;
        $display("[FAIL] buzzer pulse length: got %h, expected %h", act, exp);
    end
endtask

function automatic logic [15:0] digit_key(input int d);
    logic [15:0] k;
    k = '0;
    k[DIGIT_KEY_BIT[d]] = 1'b1;
    return k;
endfunction

// hold a key, release it, then advance the model
task automatic press_hold(input logic [15:0] k, input int hold);
    @(posedge clk);
    keys <= k;
    repeat (hold) @(posedge clk);
    keys <= '0;
    repeat (2) @(posedge clk);   // rest of the release window
    model = model_step(model, k);
    -> press_done;
endtask

task automatic press_key(input logic [15:0] k);
    press_hold(k, 3);
endtask

`endif

// File: bench/keypad_lock_tb.sv
`timescale 1ns/10ps
`default_nettype none

module keypad_lock_tb
    import lock_pkg::*;
();

    localparam int          CLK_PERIOD  = 4;
    localparam int          BUZZ_CYCLES = 20;
    localparam int          TRIES_W     = 4;
    localparam int          MAX_TRIES   = 6;
    localparam logic [11:0] PASSCODE    = 12'h246;
    localparam int          N_DIRECTED  = 60;   // upper bound on directed presses
    localparam int          N_RANDOM    = 300;
    localparam int          N_ALARMS    = 8;
    localparam int RUN_CYCLES = (N_DIRECTED + N_RANDOM) * 6 + N_ALARMS * 25 + 100;

    logic               clk;
    logic               arst_n;
    logic [15:0]        keys;
    display_u           display;
    logic [1:0]         digit_count;
    logic [TRIES_W-1:0] tries;
    logic               buzzer;

    int err_display = 0;
    int err_count   = 0;
    int err_tries   = 0;
    int err_buzz    = 0;
    int err_other   = 0;
    int buzz_len    = 0;
    int buzz_pulses = 0;
    int sel;
    logic [15:0] k;
    event press_done;

    `include "lock_model.svh"

    keypad_lock #(
        .BUZZ_CYCLES (BUZZ_CYCLES)
    ) DUT (
        .clk         (clk),
        .arst_n      (arst_n),
        .keys        (keys),
        .display     (display),
        .digit_count (digit_count),
        .tries       (tries),
        .buzzer      (buzzer)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(RUN_CYCLES * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles", RUN_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

    // compare against the model once each press has settled
    initial begin
        forever begin
            @(press_done);
            @(negedge clk);
            check_display(display, model_display(model));
            check_count(digit_count, model.count);
            check_tries(tries, model.tries);
        end
    end

    // length of every buzzer pulse
    always @(negedge clk) begin
        if (buzzer === 1'b1) begin
            buzz_len = buzz_len + 1;
        end else if (buzz_len != 0) begin
            check_buzz_len(buzz_len, BUZZ_CYCLES);
            buzz_pulses = buzz_pulses + 1;
            buzz_len    = 0;
        end
    end

    task automatic expect_outputs(input display_u d, input logic [1:0] c,
                                  input logic [TRIES_W-1:0] t);
        @(negedge clk);
        check_display(display, d);
        check_count(digit_count, c);
        check_tries(tries, t);
    endtask

    task automatic wait_pulses(input int target);
        int n;
        n = 0;
        while (buzz_pulses < target && n < BUZZ_CYCLES + 20) begin
            @(negedge clk);
            n++;
        end
        if (buzz_pulses < target) begin
            err_other++;
            $display("buzzer pulse %0d never finished", target);
        end
    endtask

    initial begin
        keys        = '0;
        arst_n      = 1'b0;
        model.entry = 12'hFFF;
        model.count = 2'd0;
        model.tries = '0;
        model.st    = M_ENTRY;
        void'($urandom(32'hac41ebef));
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        expect_outputs(GLYPH_BLANK, 2'd0, '0);

        // digit entry, overflow, illegal and held keys
        press_key(digit_key(1));
        press_key(digit_key(2));
        press_key(digit_key(3));
        press_key(digit_key(5));   // fourth digit dropped
        expect_outputs(12'h123, 2'd3, '0);
        press_key(16'h1000);
        press_key(digit_key(1) | digit_key(2));
        press_key(16'h0002);
        press_key(16'h0010);
        press_hold(digit_key(7), 12);
        expect_outputs(12'hFF7, 2'd1, '0);

        // correct code
        press_key(16'h1000);
        press_key(digit_key(2));
        press_key(digit_key(4));
        press_key(digit_key(6));
        press_key(16'h0001);
        press_key(digit_key(9));
        expect_outputs(GLYPH_OPEN, 2'd3, '0);
        press_key(16'h1000);

        // wrong code, then a short entry
        press_key(digit_key(1));
        press_key(digit_key(2));
        press_key(digit_key(3));
        press_key(16'h0001);
        expect_outputs(GLYPH_BLANK, 2'd0, 4'd1);
        wait_pulses(1);
        press_key(digit_key(5));
        press_key(digit_key(5));
        press_key(16'h0001);
        expect_outputs(12'hF55, 2'd2, 4'd1);
        press_key(16'h1000);

        // lockout and recovery
        press_key(16'h0100);
        repeat (MAX_TRIES) begin
            press_key(digit_key(1));
            press_key(digit_key(1));
            press_key(digit_key(1));
            press_key(16'h0001);
        end
        press_key(digit_key(2));
        press_key(16'h0001);
        press_key(16'h1000);
        expect_outputs(GLYPH_LOCKOUT, 2'd0, 4'(MAX_TRIES));
        press_key(16'h0100);
        expect_outputs(GLYPH_BLANK, 2'd0, '0);

        repeat (N_RANDOM) begin
            sel = $urandom_range(31, 0);
            if (sel < 16) begin
                k = digit_key($urandom_range(9, 0));
            end else if (sel < 22) begin
                k = 16'h0001;
            end else if (sel < 24) begin
                k = 16'h1000;
            end else if (sel == 24) begin
                k = 16'h0100;
            end else if (sel < 28) begin
                k = digit_key($urandom_range(9, 0)) | digit_key($urandom_range(9, 0));
            end else begin
                k = 16'($urandom);   // mostly junk patterns
            end
            press_key(k);
        end

        repeat (4) @(posedge clk);
        $display("error counts: display %0d, digit_count %0d, tries %0d, buzzer %0d, other %0d",
                 err_display, err_count, err_tries, err_buzz, err_other);
        if (err_display + err_count + err_tries + err_buzz + err_other == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+bench
src/lock_pkg.sv
src/keypad_decoder.sv
src/code_register.sv
src/lock_fsm.sv
src/alarm_timer.sv
src/keypad_lock.sv
bench/keypad_lock_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the keypad lock testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module keypad_lock_tb -f build.f \
    -o keypad_lock_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/keypad_lock_sim > sim.log 2>&1 || { cat sim.log; echo "run aborted"; exit 1; }
cat sim.log
grep -q "TESTS FAILED" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "TESTS PASSED" sim.log || { echo "no pass line in sim.log"; exit 1; }
echo "simulation ok"
